/* rtl/synth_pkg.sv */
`default_nettype none

package synth_pkg;

    localparam int sample_w     = 8;
    localparam int word_w       = 16;  // Sample byte sent twice
    localparam int freq_w       = 6;
    localparam int clks_per_bit = 8;   // UART bit period
    localparam int step_base    = 8;   // Clocks per frequency-code unit
    localparam int fifo_depth   = 4;

    localparam int lfsr_w             = 16;
    localparam logic [15:0] lfsr_seed = 16'hACE1;

    // Derived counter widths
    localparam int bit_cnt_w   = $clog2(clks_per_bit);
    localparam int step_cnt_w  = $clog2(step_base << freq_w);
    localparam int word_cnt_w  = $clog2(word_w);
    localparam int fifo_ptr_w  = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = fifo_ptr_w + 1;

    typedef enum logic [1:0] {
        wave_triangle = 2'd0,
        wave_sawtooth = 2'd1,
        wave_square   = 2'd2
    } wave_e;

    // Command bytes are plain ASCII letters
    typedef enum logic [7:0] {
        cmd_noise_on  = 8'h4E,  // N
        cmd_noise_off = 8'h46,  // F
        cmd_triangle  = 8'h54,  // T
        cmd_sawtooth  = 8'h53,  // S
        cmd_square    = 8'h51   // Q
    } cmd_e;

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,
        rx_start = 2'd1,
        rx_data  = 2'd2,
        rx_stop  = 2'd3
    } rx_state_e;

endpackage

`default_nettype wire

/* rtl/uart_command_rx.sv */
`default_nettype none

module uart_command_rx
    import synth_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx,         // Idle high
    output wave_e             wave_sel,
    output logic              noise_en,
    output logic [freq_w-1:0] freq_code,
    output logic              restart     // One cycle on waveform or noise command
);

    rx_state_e            state;
    logic [bit_cnt_w-1:0] bit_cnt;    // Clocks into current bit
    logic [2:0]           bit_idx;    // Data bit number
    logic [7:0]           rx_byte;    // LSB first shift register
    logic                 byte_done;  // Good stop bit seen
    logic                 bit_tick;
    logic                 half_tick;

    assign bit_tick  = bit_cnt == bit_cnt_w'(clks_per_bit - 1);
    assign half_tick = bit_cnt == bit_cnt_w'(clks_per_bit / 2 - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= rx_idle;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            bit_cnt   <= bit_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (!rx) begin
                        state <= rx_start;  // Falling edge
                    end
                end
                rx_start: begin
                    if (half_tick) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx ? rx_idle : rx_data;  // Glitch goes back to idle
                    end
                end
                rx_data: begin
                    if (bit_tick) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (bit_tick) begin
                        byte_done <= rx;  // Framing error drops the byte
                        state     <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rx_data && bit_tick) begin
            rx_byte <= {rx, rx_byte[7:1]};
        end
    end

    // Settings update one clock after the stop bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wave_sel  <= wave_triangle;
            noise_en  <= 1'b0;
            freq_code <= '0;
            restart   <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (byte_done) begin
                case (rx_byte)
                    cmd_noise_on: begin
                        noise_en <= 1'b1;
                        restart  <= 1'b1;
                    end
                    cmd_noise_off: begin
                        noise_en <= 1'b0;
                        restart  <= 1'b1;
                    end
                    cmd_triangle: begin
                        wave_sel <= wave_triangle;
                        restart  <= 1'b1;
                    end
                    cmd_sawtooth: begin
                        wave_sel <= wave_sawtooth;
                        restart  <= 1'b1;
                    end
                    cmd_square: begin
                        wave_sel <= wave_square;
                        restart  <= 1'b1;
                    end
                    default: freq_code <= rx_byte[freq_w-1:0];  // Anything else is a rate
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/wave_oscillator.sv */
`default_nettype none

module wave_oscillator
    import synth_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  wave_e               wave_sel,
    input  logic                noise_en,
    input  logic [freq_w-1:0]   freq_code,
    input  logic                restart,
    output logic                sample_valid,
    input  logic                sample_ready,
    output logic [sample_w-1:0] sample_data
);

    logic [step_cnt_w-1:0] step_cnt;
    logic [step_cnt_w-1:0] step_last;  // Step period minus one
    logic                  step_end;
    logic                  take;       // Step produces a sample
    logic [sample_w-1:0]   tri_val;
    logic                  tri_up;
    logic [sample_w-1:0]   saw_val;
    logic                  sq_high;
    logic [lfsr_w-1:0]     lfsr;
    logic                  lfsr_fb;
    logic [sample_w-1:0]   gen_val;    // Value of the active generator

    assign step_last = step_cnt_w'(step_base * (int'(freq_code) + 1) - 1);
    // Also catches a counter left above a newly shortened period
    assign step_end  = step_cnt >= step_last;

    // A pending sample blocks the step, so the generator holds
    assign take = step_end && !restart && (!sample_valid || sample_ready);

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_comb begin
        if (noise_en) begin
            gen_val = lfsr[lfsr_w-1 -: sample_w];  // Upper byte
        end else begin
            case (wave_sel)
                wave_sawtooth: gen_val = saw_val;
                wave_square:   gen_val = {sample_w{sq_high}};
                default:       gen_val = tri_val;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (restart || step_end) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Reset and restart both put every generator at its start
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            tri_val <= '0;
            tri_up  <= 1'b1;
            saw_val <= '0;
            sq_high <= 1'b0;
            lfsr    <= lfsr_seed;
        end else if (take) begin
            if (noise_en) begin
                lfsr <= {lfsr[lfsr_w-2:0], lfsr_fb};
            end else begin
                case (wave_sel)
                    wave_sawtooth: saw_val <= saw_val + 1'b1;  // Wraps 255 to 0
                    wave_square:   sq_high <= !sq_high;
                    default: begin
                        if (tri_up) begin
                            if (&tri_val) begin
                                tri_up  <= 1'b0;  // Peak emitted once
                                tri_val <= tri_val - 1'b1;
                            end else begin
                                tri_val <= tri_val + 1'b1;
                            end
                        end else begin
                            if (tri_val == '0) begin
                                tri_up  <= 1'b1;  // Trough emitted once
                                tri_val <= tri_val + 1'b1;
                            end else begin
                                tri_val <= tri_val - 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else if (take) begin
            sample_valid <= 1'b1;
        end else if (sample_ready) begin
            sample_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sample_data <= gen_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/sample_fifo.sv */
`default_nettype none

module sample_fifo
    import synth_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [sample_w-1:0] in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [sample_w-1:0] out_data
);

    logic [sample_w-1:0]   mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  push;
    logic                  pop;

    assign out_valid = count != '0;
    assign in_ready  = (count != fifo_cnt_w'(fifo_depth)) || out_ready;  // Full may swap
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_cnt_w'(push) - fifo_cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/i2s_serializer.sv */
`default_nettype none

module i2s_serializer
    import synth_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_valid,
    output logic                sample_ready,  // One cycle per word
    input  logic [sample_w-1:0] sample_data,
    output logic                sck,
    output logic                ws,
    output logic                sd
);

    logic [word_cnt_w-1:0] bit_cnt;      // Bits sent in current word
    logic [word_w-1:0]     shift_reg;
    logic [sample_w-1:0]   last_sample;  // Resent on underrun
    logic [sample_w-1:0]   next_sample;
    logic [word_w-1:0]     next_word;
    logic                  last_bit;
    logic                  word_end;

    assign last_bit    = bit_cnt == word_cnt_w'(word_w - 1);
    assign word_end    = sck && last_bit;  // Falling sck edge ending the word
    assign next_sample = (sample_valid && sample_ready) ? sample_data : last_sample;
    assign next_word   = {next_sample, next_sample};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck          <= 1'b0;
            ws           <= 1'b0;
            sd           <= 1'b0;
            bit_cnt      <= '0;
            shift_reg    <= '0;
            last_sample  <= '0;
            sample_ready <= 1'b0;
        end else begin
            sck          <= !sck;
            sample_ready <= !sck && last_bit;  // High during the boundary cycle
            if (word_end) begin
                bit_cnt     <= '0;
                ws          <= !ws;  // Moves with the first bit
                last_sample <= next_sample;
                sd          <= next_word[word_w-1];
                shift_reg   <= {next_word[word_w-2:0], 1'b0};
            end else if (sck) begin
                // sd only changes as sck falls
                bit_cnt   <= bit_cnt + 1'b1;
                sd        <= shift_reg[word_w-1];
                shift_reg <= {shift_reg[word_w-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/waves_synth.sv */
`default_nettype none

module waves_synth
    import synth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic i2s_sck,
    output logic i2s_ws,
    output logic i2s_sd
);

    wave_e               wave_sel;
    logic                noise_en;
    logic [freq_w-1:0]   freq_code;
    logic                restart;
    logic                sample_valid;
    logic                sample_ready;
    logic [sample_w-1:0] sample_data;
    logic                out_valid;
    logic                out_ready;
    logic [sample_w-1:0] out_data;

    uart_command_rx cmd_rx_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (uart_rx),
        .wave_sel  (wave_sel),
        .noise_en  (noise_en),
        .freq_code (freq_code),
        .restart   (restart)
    );

    wave_oscillator osc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wave_sel     (wave_sel),
        .noise_en     (noise_en),
        .freq_code    (freq_code),
        .restart      (restart),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample_data  (sample_data)
    );

    sample_fifo fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_ready  (sample_ready),
        .in_data   (sample_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    i2s_serializer i2s_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (out_valid),
        .sample_ready (out_ready),
        .sample_data  (out_data),
        .sck          (i2s_sck),
        .ws           (i2s_ws),
        .sd           (i2s_sd)
    );

endmodule

`default_nettype wire

/* verif/waves_synth_tb.sv */
`default_nettype none

module waves_synth_tb
    import synth_pkg::*;
();

    localparam int timeout_cycles = 60000;

    logic clk;
    logic rst_n;
    logic uart_rx;
    logic i2s_sck;
    logic i2s_ws;
    logic i2s_sd;

    logic [word_w-1:0] word_q [$];  // Decoded I2S words
    logic [word_w-1:0] shift_word;
    logic              ws_prev;
    logic              framed;      // First ws toggle seen
    int                bit_count;
    int                frame_errors;
    int                cycle_count;
    int                pass_count;
    int                fail_count;

    waves_synth dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .i2s_sck (i2s_sck),
        .i2s_ws  (i2s_ws),
        .i2s_sd  (i2s_sd)
    );

    always #2 clk = !clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Run timed out after %0d cycles", timeout_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // I2S decoder framing a word at each ws toggle
    always @(posedge i2s_sck) begin
        if (i2s_ws != ws_prev) begin
            if (framed && bit_count != word_w) begin
                $display("Word framing error: ws toggled after %0d bits, expected %0d",
                         bit_count, word_w);
                frame_errors++;
            end
            framed    = 1'b1;
            bit_count = 0;
        end
        ws_prev    = i2s_ws;
        shift_word = {shift_word[word_w-2:0], i2s_sd};  // MSB first
        bit_count++;
        if (framed && bit_count == word_w) begin
            word_q.push_back(shift_word);
        end
    end

    task automatic send_byte(input logic [7:0] data);
        int i;
        @(negedge clk);
        uart_rx = 1'b0;  // Start bit
        repeat (clks_per_bit) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rx = data[i];  // LSB first
            repeat (clks_per_bit) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (2 * clks_per_bit) @(negedge clk);  // Stop bit and idle
    endtask

    // Stale words before the command are dropped
    task automatic send_and_flush(input logic [7:0] data);
        send_byte(data);
        word_q.delete();
    endtask

    task automatic next_word(output logic [word_w-1:0] word);
        wait (word_q.size() > 0);
        word = word_q.pop_front();
    endtask

    // Sample n after a restart by the waveform rules
    function automatic logic [7:0] expected_at(input wave_e wave, input logic noise, input int n);
        logic [15:0] state;
        int          k;
        int          p;
        expected_at = 8'h00;
        if (noise) begin
            state = 16'hACE1;
            for (k = 0; k < n; k++) begin
                state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
            end
            expected_at = state[15:8];
        end else begin
            case (wave)
                wave_sawtooth: expected_at = 8'(n % 256);
                wave_square:   expected_at = (n % 2 == 0) ? 8'h00 : 8'hFF;
                default: begin
                    p = n % 510;  // Peak and trough once per period
                    expected_at = 8'((p <= 255) ? p : 510 - p);
                end
            endcase
        end
    endfunction

    // Finds the first three samples and checks the rest word by word
    task automatic check_sequence(input string name, input wave_e wave, input logic noise,
                                  input int count, output int errs);
        logic [word_w-1:0] w;
        logic [word_w-1:0] w0;
        logic [word_w-1:0] w1;
        logic [word_w-1:0] w2;
        logic [7:0]        e;
        int                seen;
        int                n;
        logic              synced;
        errs   = 0;
        seen   = 0;
        synced = 1'b0;
        w1     = '0;
        w2     = '0;
        while (!synced && seen < fifo_depth + 2 + 3) begin
            next_word(w);
            w0 = w1;
            w1 = w2;
            w2 = w;
            seen++;
            if (seen >= 3 && w0 == {2{expected_at(wave, noise, 0)}}
                && w1 == {2{expected_at(wave, noise, 1)}}
                && w2 == {2{expected_at(wave, noise, 2)}}) begin
                synced = 1'b1;
            end
        end
        if (!synced) begin
            $display("%s: sequence start not found within %0d words", name, seen);
            errs++;
        end else begin
            for (n = 3; n < count; n++) begin
                next_word(w);
                e = expected_at(wave, noise, n);
                if (w !== {e, e}) begin
                    $display("FAIL %s: word %0d expected %h, actual %h", name, n, {e, e}, w);
                    errs++;
                    break;  // Later words would all be shifted
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s: %0d error(s)", name, errs);
        end
    endtask

    task automatic reset_and_format();
        logic [word_w-1:0] w;
        int                errs;
        int                i;
        errs  = 0;
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        if ({i2s_sck, i2s_ws, i2s_sd} !== 3'b000) begin
            $display("FAIL reset_format: outputs expected 000, actual %b",
                     {i2s_sck, i2s_ws, i2s_sd});
            errs++;
        end
        rst_n = 1'b1;
        for (i = 0; i < 8; i++) begin
            next_word(w);
            if (w[15:8] !== w[7:0]) begin
                $display("FAIL reset_format: word %0d expected %h, actual %h",
                         i, {2{w[7:0]}}, w);
                errs++;
            end
        end
        report_test("reset_format", errs + frame_errors);
    endtask

    task automatic sawtooth_sequence();
        int errs;
        int base;
        base = frame_errors;
        send_and_flush(cmd_sawtooth);
        check_sequence("sawtooth", wave_sawtooth, 1'b0, 300, errs);
        report_test("sawtooth", errs + frame_errors - base);
    endtask

    task automatic triangle_and_square();
        int errs;
        int sq_errs;
        int base;
        base = frame_errors;
        send_and_flush(cmd_triangle);
        check_sequence("triangle_square", wave_triangle, 1'b0, 520, errs);
        send_and_flush(cmd_square);
        check_sequence("triangle_square", wave_square, 1'b0, 20, sq_errs);
        report_test("triangle_square", errs + sq_errs + frame_errors - base);
    endtask

    task automatic noise_on_off();
        int errs;
        int tri_errs;
        int base;
        base = frame_errors;
        send_byte(cmd_triangle);  // Noise off falls back to triangle
        send_and_flush(cmd_noise_on);
        check_sequence("noise", wave_triangle, 1'b1, 50, errs);
        send_and_flush(cmd_noise_off);
        check_sequence("noise", wave_triangle, 1'b0, 40, tri_errs);
        report_test("noise", errs + tri_errs + frame_errors - base);
    endtask

    // Checks runs of repeated values and steps of one between runs
    task automatic frequency_code_rate();
        logic [word_w-1:0] w;
        logic [7:0]        prev;
        logic [7:0]        code;
        int                errs;
        int                base;
        int                run;
        int                changes;
        int                i;
        logic              first_run;
        errs = 0;
        base = frame_errors;
        send_byte(cmd_sawtooth);
        send_and_flush(8'h0F);  // 128 clocks per step
        repeat (12) next_word(w);
        prev      = w[7:0];
        run       = 1;
        first_run = 1'b1;
        for (i = 0; i < 40; i++) begin
            next_word(w);
            if (w[15:8] !== w[7:0]) begin
                $display("FAIL frequency_code: word expected %h, actual %h", {2{w[7:0]}}, w);
                errs++;
            end else if (w[7:0] == prev) begin
                run++;
            end else begin
                if (w[7:0] != prev + 8'd1) begin
                    $display("FAIL frequency_code: value expected %h, actual %h",
                             prev + 8'd1, w[7:0]);
                    errs++;
                end
                if (!first_run && (run < 3 || run > 5)) begin
                    $display("FAIL frequency_code: run length expected 3 to 5, actual %0d", run);
                    errs++;
                end
                first_run = 1'b0;
                run       = 1;
                prev      = w[7:0];
            end
        end
        code = 8'($urandom % 32'h40);  // Below every command letter
        send_and_flush(code);
        next_word(w);
        prev    = w[7:0];
        changes = 0;
        for (i = 0; i < 48; i++) begin
            next_word(w);
            if (w[15:8] !== w[7:0]) begin
                $display("FAIL frequency_code: word expected %h, actual %h", {2{w[7:0]}}, w);
                errs++;
            end else if (w[7:0] != prev) begin
                if (w[7:0] != prev + 8'd1) begin
                    $display("FAIL frequency_code: code %h value expected %h, actual %h",
                             code, prev + 8'd1, w[7:0]);
                    errs++;
                end
                changes++;
                prev = w[7:0];
            end
        end
        if (changes == 0) begin
            $display("FAIL frequency_code: value changes expected at least 1, actual 0");
            errs++;
        end
        report_test("frequency_code", errs + frame_errors - base);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        uart_rx      = 1'b1;  // Line idles high
        ws_prev      = 1'b0;
        framed       = 1'b0;
        bit_count    = 0;
        shift_word   = '0;
        frame_errors = 0;
        cycle_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        void'($urandom(6300));

        reset_and_format();
        sawtooth_sequence();
        triangle_and_square();
        noise_on_off();
        frequency_code_rate();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* waves_synth.f */
rtl/synth_pkg.sv
rtl/uart_command_rx.sv
rtl/wave_oscillator.sv
rtl/sample_fifo.sv
rtl/i2s_serializer.sv
rtl/waves_synth.sv
verif/waves_synth_tb.sv
